//--- src/eth_fcs_pkg.sv
`default_nettype none

package eth_fcs_pkg;

    // one beat of a byte-wide stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_byte_t;

    // ethernet CRC-32, reflected form, shifted lsb first
    localparam logic [31:0] crc_init    = 32'hffff_ffff;
    localparam logic [31:0] crc_poly    = 32'hedb8_8320;

    // register value after a frame plus its correct FCS
    localparam logic [31:0] crc_residue = 32'hdebb_20e3;

    // frame sizes in bytes, FCS included in the minimum
    localparam int min_frame_length = 64;
    localparam int fcs_bytes        = 4;

endpackage

`default_nettype wire

//--- src/eth_crc_8.sv
`default_nettype none

module eth_crc_8 (
    input  wire  [7:0]  data_in,
    input  wire  [31:0] crc_state,
    output logic [31:0] crc_next
);
    import eth_fcs_pkg::*;

    // eight serial steps, bit 0 of the byte first
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_in[i]) begin
                crc_next = (crc_next >> 1) ^ crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/axis_skid_buffer.sv
`default_nettype none

module axis_skid_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire eth_fcs_pkg::axis_byte_t in_beat,
    input  wire                          in_valid,
    output logic                         ready_early,
    output logic                         ready_int,
    output eth_fcs_pkg::axis_byte_t      out_beat,
    output logic                         out_valid,
    input  wire                          out_ready
);
    import eth_fcs_pkg::*;

    // spare register, catches the beat already in flight when output stalls
    axis_byte_t temp_beat;
    logic       temp_valid;

    // next cycle can take a beat if downstream drains,
    // or if temp stays empty and one register is still free
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_int  <= 1'b0;
            out_beat   <= '0;
            out_valid  <= 1'b0;
            temp_beat  <= '0;
            temp_valid <= 1'b0;
        end else begin
            ready_int <= ready_early;

            if (ready_int) begin
                if (out_ready || !out_valid) begin
                    // output free or moving, load it directly
                    out_beat  <= in_beat;
                    out_valid <= in_valid;
                end else begin
                    // output held, park in temp
                    temp_beat  <= in_beat;
                    temp_valid <= in_valid;
                end
            end else if (out_ready) begin
                // upstream paused, drain temp first
                out_beat   <= temp_beat;
                out_valid  <= temp_valid;
                temp_beat  <= '0;
                temp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/axis_eth_fcs_insert.sv
`default_nettype none

module axis_eth_fcs_insert #(
    parameter bit enable_padding = 1'b0
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire eth_fcs_pkg::axis_byte_t in_beat,
    input  wire                          in_valid,
    output logic                         in_ready,
    output eth_fcs_pkg::axis_byte_t      out_beat,
    output logic                         out_valid,
    input  wire                          out_ready,
    output logic                         busy
);
    import eth_fcs_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_pad,
        st_fcs
    } state_t;

    state_t      state;
    state_t      state_next;
    logic [7:0]  frame_ptr;
    logic [7:0]  frame_ptr_next;
    logic [7:0]  frame_ptr_inc;
    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic        crc_reset;
    logic        crc_update;
    logic        in_ready_next;

    axis_byte_t  int_beat;
    logic        int_valid;
    logic        ready_early;
    logic        ready_int;

    // saturates so long frames never look short again
    assign frame_ptr_inc = (frame_ptr == 8'hff) ? frame_ptr : frame_ptr + 8'd1;

    // crc follows whatever goes into the buffer, pad bytes included
    eth_crc_8 crc_i (
        .data_in   (int_beat.data),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        crc_reset      = 1'b0;
        crc_update     = 1'b0;
        in_ready_next  = 1'b0;
        int_beat       = '0;
        int_valid      = 1'b0;

        case (state)
            st_idle, st_payload: begin
                in_ready_next = ready_early;
                int_beat.data = in_beat.data;
                int_valid     = in_valid && in_ready;
                if (state == st_idle) begin
                    frame_ptr_next = '0;
                    crc_reset      = 1'b1;
                end

                if (in_valid && in_ready) begin
                    crc_reset      = 1'b0;
                    crc_update     = 1'b1;
                    frame_ptr_next = frame_ptr_inc;
                    state_next     = st_payload;
                    if (in_beat.last) begin
                        if (in_beat.user) begin
                            // aborted frame, pass the flag on and skip the FCS
                            int_beat.last  = 1'b1;
                            int_beat.user  = 1'b1;
                            crc_reset      = 1'b1;
                            frame_ptr_next = '0;
                            state_next     = st_idle;
                        end else begin
                            in_ready_next = 1'b0;
                            if (enable_padding &&
                                frame_ptr < 8'(min_frame_length - fcs_bytes - 1)) begin
                                state_next = st_pad;
                            end else begin
                                frame_ptr_next = '0;
                                state_next     = st_fcs;
                            end
                        end
                    end
                end
            end

            st_pad: begin
                // zero bytes up to the minimum length less FCS
                int_valid = 1'b1;
                if (ready_int) begin
                    crc_update     = 1'b1;
                    frame_ptr_next = frame_ptr_inc;
                    if (frame_ptr >= 8'(min_frame_length - fcs_bytes - 1)) begin
                        frame_ptr_next = '0;
                        state_next     = st_fcs;
                    end
                end
            end

            st_fcs: begin
                // inverted crc, low byte first
                int_beat.data = ~crc_state[8 * frame_ptr[1:0] +: 8];
                int_valid     = 1'b1;
                if (ready_int) begin
                    frame_ptr_next = frame_ptr_inc;
                    if (frame_ptr == 8'(fcs_bytes - 1)) begin
                        int_beat.last  = 1'b1;
                        crc_reset      = 1'b1;
                        frame_ptr_next = '0;
                        in_ready_next  = ready_early;
                        state_next     = st_idle;
                    end
                end
            end

            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            frame_ptr <= '0;
            in_ready  <= 1'b0;
            busy      <= 1'b0;
            crc_state <= crc_init;
        end else begin
            state     <= state_next;
            frame_ptr <= frame_ptr_next;
            in_ready  <= in_ready_next;
            busy      <= (state_next != st_idle);
            if (crc_reset) begin
                crc_state <= crc_init;
            end else if (crc_update) begin
                crc_state <= crc_next;
            end
        end
    end

    axis_skid_buffer out_buf_i (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (int_beat),
        .in_valid    (int_valid),
        .ready_early (ready_early),
        .ready_int   (ready_int),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

//--- src/axis_eth_fcs_check.sv
`default_nettype none

module axis_eth_fcs_check (
    input  wire                          clk,
    input  wire                          rst,
    input  wire eth_fcs_pkg::axis_byte_t in_beat,
    input  wire                          in_valid,
    output logic                         in_ready,
    output eth_fcs_pkg::axis_byte_t      out_beat,
    output logic                         out_valid,
    input  wire                          out_ready,
    output logic                         busy
);
    import eth_fcs_pkg::*;

    // last four accepted bytes, index 0 is the oldest
    logic [fcs_bytes-1:0][7:0] delay_line;
    logic [2:0]                fill;
    logic                      fill_full;
    logic [31:0]               crc_state;
    logic [31:0]               crc_next;
    logic                      crc_bad;
    logic                      accept;

    axis_byte_t                int_beat;
    logic                      int_valid;
    logic                      ready_early;
    logic                      ready_int;

    assign fill_full = (fill == 3'(fcs_bytes));

    // in_ready and ready_int are both ready_early one cycle later
    assign accept = in_valid && in_ready && ready_int;

    // residue check runs over the whole frame, FCS included
    eth_crc_8 crc_i (
        .data_in   (in_beat.data),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    assign crc_bad = in_beat.user || (crc_next != crc_residue);

    // each byte past the fourth releases the oldest held one
    always_comb begin
        int_valid     = accept && fill_full;
        int_beat.data = delay_line[0];
        int_beat.last = int_valid && in_beat.last;
        int_beat.user = int_valid && in_beat.last && crc_bad;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready  <= 1'b0;
            fill      <= '0;
            busy      <= 1'b0;
            crc_state <= crc_init;
        end else begin
            in_ready <= ready_early;
            if (accept) begin
                if (in_beat.last) begin
                    // end of frame, flush the held FCS bytes
                    fill      <= '0;
                    busy      <= 1'b0;
                    crc_state <= crc_init;
                end else begin
                    if (!fill_full) begin
                        fill <= fill + 3'd1;
                    end
                    busy      <= 1'b1;
                    crc_state <= crc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            delay_line <= {in_beat.data, delay_line[fcs_bytes-1:1]};
        end
    end

    axis_skid_buffer out_buf_i (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (int_beat),
        .in_valid    (int_valid),
        .ready_early (ready_early),
        .ready_int   (ready_int),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

//--- src/eth_fcs_top.sv
`default_nettype none

module eth_fcs_top (
    input  wire                          clk,
    input  wire                          rst,

    input  wire eth_fcs_pkg::axis_byte_t tx_in,
    input  wire                          tx_in_valid,
    output logic                         tx_in_ready,
    output eth_fcs_pkg::axis_byte_t      tx_out,
    output logic                         tx_out_valid,
    input  wire                          tx_out_ready,

    input  wire eth_fcs_pkg::axis_byte_t rx_in,
    input  wire                          rx_in_valid,
    output logic                         rx_in_ready,
    output eth_fcs_pkg::axis_byte_t      rx_out,
    output logic                         rx_out_valid,
    input  wire                          rx_out_ready,

    output logic                         tx_busy,
    output logic                         rx_busy
);

    // transmit path, pads short frames
    axis_eth_fcs_insert #(
        .enable_padding (1'b1)
    ) insert_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (tx_in),
        .in_valid  (tx_in_valid),
        .in_ready  (tx_in_ready),
        .out_beat  (tx_out),
        .out_valid (tx_out_valid),
        .out_ready (tx_out_ready),
        .busy      (tx_busy)
    );

    // receive path
    axis_eth_fcs_check check_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (rx_in),
        .in_valid  (rx_in_valid),
        .in_ready  (rx_in_ready),
        .out_beat  (rx_out),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready),
        .busy      (rx_busy)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- sim/eth_fcs_top_properties.sv
`default_nettype none

module eth_fcs_top_properties (
    input wire                          clk,
    input wire                          rst,
    input wire                          tx_in_ready,
    input wire eth_fcs_pkg::axis_byte_t tx_out,
    input wire                          tx_out_valid,
    input wire                          tx_out_ready,
    input wire                          rx_in_ready,
    input wire eth_fcs_pkg::axis_byte_t rx_out,
    input wire                          rx_out_valid,
    input wire                          rx_out_ready
);

    int fail_count = 0;

    // a stalled beat stays put until taken
    tx_hold_a: assert property (@(posedge clk) disable iff (rst)
        tx_out_valid && !tx_out_ready |=> tx_out_valid && $stable(tx_out))
        else begin
            $error("tx_out changed or dropped while stalled");
            fail_count++;
        end

    rx_hold_a: assert property (@(posedge clk) disable iff (rst)
        rx_out_valid && !rx_out_ready |=> rx_out_valid && $stable(rx_out))
        else begin
            $error("rx_out changed or dropped while stalled");
            fail_count++;
        end

    // handshake outputs quiet during reset
    reset_quiet_a: assert property (@(posedge clk)
        rst |-> !(tx_out_valid || rx_out_valid || tx_in_ready || rx_in_ready))
        else begin
            $error("valid or ready high during reset");
            fail_count++;
        end

    tx_last_a: assert property (@(posedge clk) disable iff (rst)
        tx_out.last |-> tx_out_valid)
        else begin
            $error("tx_out last without valid");
            fail_count++;
        end

    rx_last_a: assert property (@(posedge clk) disable iff (rst)
        rx_out.last |-> rx_out_valid)
        else begin
            $error("rx_out last without valid");
            fail_count++;
        end

endmodule

bind eth_fcs_top eth_fcs_top_properties props_i (.*);

`default_nettype wire

//--- sim/eth_fcs_tb.sv
`default_nettype none

module eth_fcs_tb;
    import eth_fcs_pkg::*;

    logic       clk;
    logic       rst;
    axis_byte_t tx_in;
    logic       tx_in_valid;
    logic       tx_in_ready;
    axis_byte_t tx_out;
    logic       tx_out_valid;
    logic       tx_out_ready;
    axis_byte_t rx_in;
    logic       rx_in_valid;
    logic       rx_in_ready;
    axis_byte_t rx_out;
    logic       rx_out_valid;
    logic       rx_out_ready;
    logic       tx_busy;
    logic       rx_busy;

    logic [15:0] pat_mem [0:511];
    axis_byte_t  stim_q[$];
    axis_byte_t  exp_tx[$];
    axis_byte_t  exp_rx[$];
    axis_byte_t  tx_exp_beat;
    axis_byte_t  rx_exp_beat;
    logic        corrupt_flag [0:31];
    integer      seed = 32'h65b0_92ac;
    int          err_count;
    int          check_count;
    int          frame_count;
    int          tx_done;
    int          rx_done;
    int          total_bytes;
    logic        loaded;
    logic [7:0]  lb_pos;
    int          lb_frame;
    logic [7:0]  flip;

    tb_clock_gen #(.period(40)) clk_gen_i (.clk(clk));

    eth_fcs_top dut_i (.*);

    // loopback inverts one byte of each corrupt frame
    assign tx_out_ready = rx_in_ready;
    assign rx_in_valid  = tx_out_valid;
    assign flip  = (corrupt_flag[lb_frame] && lb_pos == 8'd5) ? 8'hff : 8'h00;
    assign rx_in = {tx_out.data ^ flip, tx_out.last, tx_out.user};

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lb_pos   <= '0;
            lb_frame <= 0;
        end else if (tx_out_valid && tx_out_ready) begin
            if (tx_out.last) begin
                lb_pos   <= '0;
                lb_frame <= lb_frame + 1;
            end else begin
                lb_pos <= lb_pos + 8'd1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // ethernet CRC-32 with each byte folded into the low bits before eight shifts
    function automatic logic [31:0] crc32_bytes(input logic [7:0] bytes[$]);
        logic [31:0] crc;
        crc = 32'hffff_ffff;
        foreach (bytes[i]) begin
            crc = crc ^ {24'h0, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic load_patterns();
        int          idx;
        int          len;
        logic        abort;
        logic        corrupt;
        logic [7:0]  frame[$];
        logic [31:0] fcs;
        idx = 0;
        $readmemh("sim/eth_fcs_patterns.txt", pat_mem);
        while (pat_mem[idx] !== 16'h0000 && !$isunknown(pat_mem[idx])) begin
            len     = pat_mem[idx][7:0];
            abort   = pat_mem[idx][8];
            corrupt = pat_mem[idx][9];
            corrupt_flag[frame_count] = corrupt;
            frame.delete();
            for (int i = 0; i < len; i++) begin
                frame.push_back(pat_mem[idx + 1 + i][7:0]);
                stim_q.push_back({pat_mem[idx + 1 + i][7:0], i == len - 1,
                                  abort && i == len - 1});
            end
            idx += len + 1;
            if (!abort) begin
                // zero pad to 60 bytes and append the FCS low byte first
                while (frame.size() < 60) begin
                    frame.push_back(8'h00);
                end
                fcs = crc32_bytes(frame);
                for (int i = 0; i < 4; i++) begin
                    frame.push_back(fcs[8 * i +: 8]);
                end
            end
            foreach (frame[i]) begin
                exp_tx.push_back({frame[i], i == frame.size() - 1,
                                  abort && i == frame.size() - 1});
            end
            total_bytes += frame.size();
            if (corrupt) begin
                frame[5] = ~frame[5];
            end
            // checker strips four bytes and drops anything shorter
            if (frame.size() > 4) begin
                for (int i = 0; i < frame.size() - 4; i++) begin
                    exp_rx.push_back({frame[i], i == frame.size() - 5,
                                      (abort || corrupt) && i == frame.size() - 5});
                end
            end
            frame_count++;
        end
    endtask

    task automatic send_beat(input axis_byte_t beat);
        logic taken;
        tx_in       = beat;
        tx_in_valid = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = tx_in_ready;
            @(posedge clk);
            #5;
        end
        tx_in_valid = 1'b0;
        tx_in       = '0;
    endtask

    always @(posedge clk) begin
        #5;
        rx_out_ready = ($random(seed) & 3) != 0;
    end

    always @(negedge clk) begin
        if (!rst && tx_out_valid && tx_out_ready) begin
            if (exp_tx.size() == 0) begin
                $display("tx_out sent a beat after all expected frames");
                err_count++;
            end else begin
                tx_exp_beat = exp_tx.pop_front();
                check_value("tx_out.data", tx_out.data, tx_exp_beat.data);
                check_value("tx_out.last", tx_out.last, tx_exp_beat.last);
                check_value("tx_out.user", tx_out.user, tx_exp_beat.user);
                if (tx_out.last) begin
                    $display("tx frame %0d done, %0d errors so far", tx_done, err_count);
                    tx_done++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && rx_out_valid && rx_out_ready) begin
            if (exp_rx.size() == 0) begin
                $display("rx_out sent a beat after all expected frames");
                err_count++;
            end else begin
                rx_exp_beat = exp_rx.pop_front();
                check_value("rx_out.data", rx_out.data, rx_exp_beat.data);
                check_value("rx_out.last", rx_out.last, rx_exp_beat.last);
                check_value("rx_out.user", rx_out.user, rx_exp_beat.user);
                if (rx_out.last) begin
                    $display("rx frame %0d done, %0d errors so far", rx_done, err_count);
                    rx_done++;
                end
            end
        end
    end

    // limit scales with the pattern length
    initial begin
        wait (loaded);
        #((total_bytes * 8 + 200) * 40);
        $display("timeout, frames did not drain in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        tx_in        = '0;
        tx_in_valid  = 1'b0;
        rx_out_ready = 1'b0;
        loaded       = 1'b0;
        foreach (corrupt_flag[i]) begin
            corrupt_flag[i] = 1'b0;
        end
        load_patterns();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        foreach (stim_q[i]) begin
            send_beat(stim_q[i]);
            if (stim_q[i].last) begin
                @(posedge clk);
                #5;
            end
        end

        while (exp_tx.size() != 0 || exp_rx.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("tx_busy", tx_busy, 0);
        check_value("rx_busy", rx_busy, 0);
        if (dut_i.props_i.fail_count != 0) begin
            $display("stream protocol assertions failed %0d times",
                     dut_i.props_i.fail_count);
            err_count += dut_i.props_i.fail_count;
        end

        $display("%0d frames, %0d tx and %0d rx frames seen, %0d checks, %0d errors",
                 frame_count, tx_done, rx_done, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- eth_fcs_top.f
src/eth_fcs_pkg.sv
src/eth_crc_8.sv
src/axis_skid_buffer.sv
src/axis_eth_fcs_insert.sv
src/axis_eth_fcs_check.sv
src/eth_fcs_top.sv
sim/tb_clock_gen.sv
sim/eth_fcs_top_properties.sv
sim/eth_fcs_tb.sv

//--- sim/eth_fcs_patterns.txt
// control word: bits 7:0 payload length, bit 8 abort, bit 9 corrupt on loopback
// payload bytes follow each control word, 0000 ends the list
000c
01 02 03 04 05 06 07 08 09 0a 0b 0c
003e
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d
0108
a0 a1 a2 a3 a4 a5 a6 a7
0103
b0 b1 b2
0214
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3
0001
5a
0000
